// ==== filelist.f ====
source/cachePkg.sv
source/lineStore.sv
source/dramBurstPort.sv
source/cacheSequencer.sv
source/m68kCache.sv
tb/dramModel.sv
tb/m68kCacheTb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = m68kCacheTb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/m68kCacheTb.sv ====
// 68k read cache testbench
`default_nettype none

module m68kCacheTb;

	import cachePkg::*;

	localparam int ResetCycles   = 5;
	localparam int HitDtackEdges = 3;    // sampling edge, then dtack two clocks later
	localparam int NumAccesses   = 17;
	localparam int TimeoutCycles = 20 * NumAccesses + NumLines + 1 + ResetCycles;

	logic                 Clock;
	logic                 Reset_L;
	logic                 AS_L;
	logic                 dramSelect68k;
	logic                 WE_L;
	logic                 UDS_L;
	logic                 LDS_L;
	logic [AddrWidth-1:0] address68k;
	logic [DataWidth-1:0] writeData68k;
	logic [DataWidth-1:0] readData68k;
	logic                 dtack_L;
	logic                 cas_L;
	logic                 ras_L;
	logic                 dramDtack_L;
	logic [DataWidth-1:0] dramReadData;
	logic                 dramSelect_L;
	logic                 dramWe_L;
	logic                 dramAs_L;
	logic                 dramUds_L;
	logic                 dramLds_L;
	logic [AddrWidth-1:0] dramAddress;
	logic [DataWidth-1:0] dramWriteData;
	logic                 insertRefresh;
	int                   readCount;
	int                   refreshCount;
	logic [AddrWidth-1:0] writeAddress;
	logic [DataWidth-1:0] writeData;
	logic                 writeUds_L;
	logic                 writeLds_L;
	int                   seed = 90042;
	int                   cycleCount = 0;

	m68kCache m68kCache_i (
		.Clock(Clock), .Reset_L(Reset_L), .AS_L(AS_L), .dramSelect68k(dramSelect68k),
		.WE_L(WE_L), .UDS_L(UDS_L), .LDS_L(LDS_L), .address68k(address68k),
		.writeData68k(writeData68k), .readData68k(readData68k), .dtack_L(dtack_L),
		.cas_L(cas_L), .ras_L(ras_L), .dramDtack_L(dramDtack_L), .dramReadData(dramReadData),
		.dramSelect_L(dramSelect_L), .dramWe_L(dramWe_L), .dramAs_L(dramAs_L),
		.dramUds_L(dramUds_L), .dramLds_L(dramLds_L), .dramAddress(dramAddress),
		.dramWriteData(dramWriteData)
	);

	dramModel dramModel_i (
		.Clock(Clock), .dramSelect_L(dramSelect_L), .dramWe_L(dramWe_L), .dramAs_L(dramAs_L),
		.dramUds_L(dramUds_L), .dramLds_L(dramLds_L), .dramAddress(dramAddress),
		.dramWriteData(dramWriteData), .insertRefresh(insertRefresh), .cas_L(cas_L),
		.ras_L(ras_L), .dramDtack_L(dramDtack_L), .dramReadData(dramReadData),
		.readCount(readCount), .refreshCount(refreshCount), .writeAddress(writeAddress),
		.writeData(writeData), .writeUds_L(writeUds_L), .writeLds_L(writeLds_L)
	);

	always #2 Clock = !Clock;

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > TimeoutCycles) begin
			$display("timeout after %0d cycles, an access never got its DTACK", cycleCount);
			abortRun();
		end
	end

	////////////////////////////////////////////////////////////
	// checks and bus tasks
	////////////////////////////////////////////////////////////

	task automatic abortRun();
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
			abortRun();
		end
	endtask

	// word at a is (a >> 1) ^ 5A5A, low 16 bits
	function automatic logic [15:0] patternWord(input logic [31:0] address);
		return address[16:1] ^ 16'h5A5A;
	endfunction

	// entered and left 1 unit after a rising edge
	task automatic read68k(input logic [31:0] address, output logic [15:0] data,
			output int edges);
		edges         = 0;
		address68k    = address;
		WE_L          = 1'b1;
		UDS_L         = 1'b0;
		LDS_L         = 1'b0;
		AS_L          = 1'b0;
		dramSelect68k = 1'b1;
		while (dtack_L) begin
			@(posedge Clock);
			edges++;           // edges from AS to dtack
			@(negedge Clock);
		end
		data = readData68k;    // valid as long as dtack is low
		@(posedge Clock);
		#1;
		AS_L          = 1'b1;
		UDS_L         = 1'b1;
		LDS_L         = 1'b1;
		dramSelect68k = 1'b0;
		while (!dtack_L) begin
			@(negedge Clock);
		end
		@(posedge Clock);
		#1;
	endtask

	task automatic write68k(input logic [31:0] address, input logic [15:0] data,
			input logic upper, input logic lower);
		address68k    = address;
		writeData68k  = data;
		WE_L          = 1'b0;
		UDS_L         = !upper;
		LDS_L         = !lower;
		AS_L          = 1'b0;
		dramSelect68k = 1'b1;
		while (dtack_L) begin
			@(negedge Clock);
		end
		@(posedge Clock);
		#1;
		AS_L          = 1'b1;
		WE_L          = 1'b1;
		UDS_L         = 1'b1;
		LDS_L         = 1'b1;
		dramSelect68k = 1'b0;
		while (!dtack_L) begin
			@(negedge Clock);
		end
		@(posedge Clock);
		#1;
	endtask

	task automatic readPattern(input logic [31:0] address, output int edges);
		logic [15:0] data;
		read68k(address, data, edges);
		checkValue("readData68k", 32'(data), 32'(patternWord(address)));
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	// raised while the invalidate sweep still runs
	task automatic coldMiss(output logic [31:0] address);
		int edges;
		address = $random(seed) & 32'hFFFF_FFFE;
		readPattern(address, edges);
		checkValue("dram read count", readCount, 1);
	endtask

	task automatic hitSameLine(input logic [31:0] firstAddress);
		logic [31:0] address;
		int          countBefore;
		int          edges;
		address     = {firstAddress[31:4], firstAddress[3:1] ^ 3'b101, 1'b0};   // other word
		countBefore = readCount;
		readPattern(address, edges);
		checkValue("dtack edges", edges, HitDtackEdges);
		checkValue("dram read count", readCount, countBefore);
	endtask

	task automatic writeThrough();
		logic [31:0] address;
		logic [15:0] newData;
		logic [15:0] data;
		logic [15:0] expected;
		int          countBefore;
		int          edges;
		address = $random(seed) & 32'hFFFF_FFFE;
		newData = 16'($random(seed));
		readPattern(address, edges);                          // line now valid
		countBefore = readCount;
		write68k(address | 32'h1, newData, 1'b1, 1'b0);       // upper byte, A0 dropped
		checkValue("dram write address", writeAddress, address);
		checkValue("dram write data", 32'(writeData), 32'(newData));
		checkValue("dram UDS", 32'(writeUds_L), 0);
		checkValue("dram LDS", 32'(writeLds_L), 1);
		expected       = patternWord(address);
		expected[15:8] = newData[15:8];
		read68k(address, data, edges);
		checkValue("dram read count", readCount, countBefore + 1);   // line was dropped
		checkValue("readData68k", 32'(data), 32'(expected));
	endtask

	task automatic refreshDuringFill();
		logic [31:0] address;
		int          countBefore;
		int          edges;
		address       = $random(seed) & 32'hFFFF_FFFE;
		countBefore   = readCount;
		insertRefresh = 1'b1;
		readPattern(address, edges);
		insertRefresh = 1'b0;
		checkValue("refresh count", refreshCount, 1);
		checkValue("dram read count", readCount, countBefore + 1);
		for (int k = 0; k < LineWords; k++) begin   // whole line hits
			readPattern({address[31:4], 3'(k), 1'b0}, edges);
			checkValue("dtack edges", edges, HitDtackEdges);
		end
		checkValue("dram read count", readCount, countBefore + 1);
	endtask

	task automatic lineConflict();
		logic [31:0] addressA;
		logic [31:0] addressB;
		int          countBefore;
		int          edges;
		addressA    = $random(seed) & 32'hFFFF_FFFE;
		addressB    = addressA ^ 32'h8001_0200;   // same index, other tag and data
		countBefore = readCount;
		readPattern(addressA, edges);
		readPattern(addressB, edges);
		readPattern(addressA, edges);             // evicted by B
		checkValue("dram read count", readCount, countBefore + 3);
	endtask

	initial begin
		logic [31:0] firstAddress;
		Clock         = 1'b0;
		Reset_L       = 1'b0;
		AS_L          = 1'b1;
		dramSelect68k = 1'b0;
		WE_L          = 1'b1;
		UDS_L         = 1'b1;
		LDS_L         = 1'b1;
		address68k    = '0;
		writeData68k  = '0;
		insertRefresh = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		#1;
		Reset_L = 1'b1;
		coldMiss(firstAddress);
		hitSameLine(firstAddress);
		writeThrough();
		refreshDuringFill();
		lineConflict();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/dramModel.sv ====
// behavioral dram controller
`default_nettype none

module dramModel (
	input  wire logic        Clock,
	input  wire logic        dramSelect_L,
	input  wire logic        dramWe_L,
	input  wire logic        dramAs_L,
	input  wire logic        dramUds_L,
	input  wire logic        dramLds_L,
	input  wire logic [31:0] dramAddress,
	input  wire logic [15:0] dramWriteData,
	input  wire logic        insertRefresh,   // refresh ahead of the read CAS while set
	output logic             cas_L,
	output logic             ras_L,
	output logic             dramDtack_L,
	output logic [15:0]      dramReadData,
	output int               readCount,       // burst reads seen
	output int               refreshCount,
	output logic [31:0]      writeAddress,    // last write as seen on the pins
	output logic [15:0]      writeData,
	output logic             writeUds_L,
	output logic             writeLds_L
);

	logic [15:0] mem [65536];   // 128 KiB, mirrored over the 68k space

	initial begin
		cas_L        = 1'b1;
		ras_L        = 1'b1;
		dramDtack_L  = 1'b1;
		dramReadData = '0;
		readCount    = 0;
		refreshCount = 0;
		writeAddress = '0;
		writeData    = '0;
		writeUds_L   = 1'b1;
		writeLds_L   = 1'b1;
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 16'(i) ^ 16'h5A5A;   // word at a holds (a >> 1) ^ 5A5A
		end
	end

	////////////////////////////////////////////////////////////
	// burst read, CAS latency two
	////////////////////////////////////////////////////////////

	task automatic burstRead();
		logic [15:0] lineIndex;
		lineIndex = dramAddress[16:1];   // already line aligned by the port
		readCount++;
		@(posedge Clock);
		#1;
		if (insertRefresh) begin
			cas_L = 1'b0;   // CAS with RAS low
			ras_L = 1'b0;
			refreshCount++;
			@(posedge Clock);
			#1;
			cas_L = 1'b1;
			ras_L = 1'b1;
			@(posedge Clock);
			#1;
		end
		cas_L = 1'b0;       // read CAS, RAS stays high
		@(posedge Clock);
		#1;
		cas_L = 1'b1;
		repeat (2) begin    // latency
			@(posedge Clock);
			#1;
		end
		for (int k = 0; k < 8; k++) begin
			dramReadData = mem[{lineIndex[15:3], 3'(k)}];   // one word per clock
			@(posedge Clock);
			#1;
		end
		while (!dramSelect_L) begin
			@(negedge Clock);
		end
	endtask

	////////////////////////////////////////////////////////////
	// single word write
	////////////////////////////////////////////////////////////

	task automatic acceptWrite();
		logic [15:0] wordIndex;
		wordIndex    = dramAddress[16:1];
		writeAddress = dramAddress;
		writeData    = dramWriteData;
		writeUds_L   = dramUds_L;
		writeLds_L   = dramLds_L;
		if (!dramUds_L) begin
			mem[wordIndex][15:8] = dramWriteData[15:8];
		end
		if (!dramLds_L) begin
			mem[wordIndex][7:0] = dramWriteData[7:0];
		end
		repeat (2) begin
			@(posedge Clock);
			#1;
		end
		dramDtack_L = 1'b0;   // held until the select drops
		while (!dramSelect_L) begin
			@(negedge Clock);
		end
		@(posedge Clock);
		#1;
		dramDtack_L = 1'b1;
	endtask

	always begin
		@(negedge Clock);   // pins settled from the last edge
		if (!dramSelect_L && !dramAs_L) begin
			if (dramWe_L) begin
				burstRead();
			end else begin
				acceptWrite();
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/m68kCache.sv ====
// 68k read cache top level
`default_nettype none

module m68kCache (
	input  wire logic                              Clock,
	input  wire logic                              Reset_L,
	// 68k side
	input  wire logic                              AS_L,
	input  wire logic                              dramSelect68k,
	input  wire logic                              WE_L,
	input  wire logic                              UDS_L,
	input  wire logic                              LDS_L,
	input  wire logic [cachePkg::AddrWidth-1:0]    address68k,
	input  wire logic [cachePkg::DataWidth-1:0]    writeData68k,
	output wire logic [cachePkg::DataWidth-1:0]    readData68k,
	output wire logic                              dtack_L,
	// dram controller side
	input  wire logic                              cas_L,
	input  wire logic                              ras_L,
	input  wire logic                              dramDtack_L,
	input  wire logic [cachePkg::DataWidth-1:0]    dramReadData,
	output wire logic                              dramSelect_L,
	output wire logic                              dramWe_L,
	output wire logic                              dramAs_L,
	output wire logic                              dramUds_L,
	output wire logic                              dramLds_L,
	output wire logic [cachePkg::AddrWidth-1:0]    dramAddress,
	output wire logic [cachePkg::DataWidth-1:0]    dramWriteData
);

	import cachePkg::*;

	cpuReqT                  request;
	storeWriteT              storeWrite;
	dramOpT                  dramOp;
	fillWordT                fillWord;
	logic                    fillDone;
	logic                    writeDtack;
	logic                    hit;
	logic                    lineValid;
	logic [WordSelWidth-1:0] readWordSel;

	// pins to active-high request
	always_comb begin
		request.active      = !AS_L && dramSelect68k;
		request.write       = !WE_L;
		request.upperStrobe = !UDS_L;
		request.lowerStrobe = !LDS_L;
		request.address     = address68k;
		request.writeData   = writeData68k;
	end

	cacheSequencer cacheSequencer_i (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.request     (request),
		.hit         (hit),
		.lineValid   (lineValid),
		.fillWord    (fillWord),
		.fillDone    (fillDone),
		.writeDtack  (writeDtack),
		.storeWrite  (storeWrite),
		.dramOp      (dramOp),
		.dtack_L     (dtack_L),
		.readWordSel (readWordSel)
	);

	lineStore lineStore_i (
		.Clock         (Clock),
		.Reset_L       (Reset_L),
		.lookupAddress (request.address),
		.storeWrite    (storeWrite),
		.readWordSel   (readWordSel),
		.hit           (hit),
		.lineValid     (lineValid),
		.readData      (readData68k)   // straight onto the 68k data bus
	);

	dramBurstPort dramBurstPort_i (
		.Clock         (Clock),
		.Reset_L       (Reset_L),
		.request       (request),
		.dramOp        (dramOp),
		.cas_L         (cas_L),
		.ras_L         (ras_L),
		.dramDtack_L   (dramDtack_L),
		.dramReadData  (dramReadData),
		.dramSelect_L  (dramSelect_L),
		.dramWe_L      (dramWe_L),
		.dramAs_L      (dramAs_L),
		.dramUds_L     (dramUds_L),
		.dramLds_L     (dramLds_L),
		.dramAddress   (dramAddress),
		.dramWriteData (dramWriteData),
		.fillWord      (fillWord),
		.fillDone      (fillDone),
		.writeDtack    (writeDtack)
	);

endmodule

`default_nettype wire

// ==== source/cacheSequencer.sv ====
// cache controller sequencer
`default_nettype none

module cacheSequencer (
	input  wire logic                                  Clock,
	input  wire logic                                  Reset_L,
	input  wire cachePkg::cpuReqT                      request,
	input  wire logic                                  hit,
	input  wire logic                                  lineValid,
	input  wire cachePkg::fillWordT                    fillWord,
	input  wire logic                                  fillDone,
	input  wire logic                                  writeDtack,
	output cachePkg::storeWriteT                       storeWrite,
	output cachePkg::dramOpT                           dramOp,
	output logic                                       dtack_L,
	output logic [cachePkg::WordSelWidth-1:0]          readWordSel
);

	import cachePkg::*;

	seqStateT              state;
	seqStateT              nextState;
	logic [IndexWidth-1:0] sweepIndex;    // line being invalidated
	logic                  holdDtack_L;   // registered dtack for read data
	logic                  lastLine;

	assign lastLine = (sweepIndex == IndexWidth'(NumLines - 1));

	////////////////////////////////////////////////////////////
	// state and sweep registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state       <= stResetSweep;
			sweepIndex  <= '0;
			holdDtack_L <= 1'b1;
		end else begin
			state <= nextState;

			if (state == stInvalidate) begin
				sweepIndex <= sweepIndex + 1'b1;   // wraps back to 0 after the last line
			end else begin
				sweepIndex <= '0;
			end

			// read data sits on the bus a full cycle before dtack falls
			holdDtack_L <= !(((state == stHitHold) || (state == stFillHold)) && request.active);
		end
	end

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		unique case (state)
			stResetSweep: nextState = stInvalidate;
			stInvalidate: begin
				if (lastLine) begin
					nextState = stIdle;
				end
			end
			stIdle: begin
				if (request.active) begin
					nextState = request.write ? stWrite : stLookup;
				end
			end
			stLookup: nextState = hit ? stHitHold : stFill;   // tag reg loaded on Idle's edge
			stFill: begin
				if (fillDone) begin
					nextState = stFillHold;
				end
			end
			stHitHold, stFillHold, stWrite: begin
				if (!request.active) begin
					nextState = stIdle;   // 68k ended the bus cycle
				end
			end
			default: nextState = stResetSweep;
		endcase
	end

	////////////////////////////////////////////////////////////
	// store writes, dram op, read word select
	////////////////////////////////////////////////////////////

	always_comb begin
		storeWrite         = '0;
		storeWrite.index   = request.address[TagLsb-1:IndexLsb];
		storeWrite.tag     = request.address[AddrWidth-1:TagLsb];
		storeWrite.wordSel = fillWord.wordSel;  // burst word position
		storeWrite.data    = fillWord.data;
		dramOp             = opNone;
		readWordSel        = '0;

		case (state)
			stInvalidate: begin
				storeWrite.index      = sweepIndex;
				storeWrite.validWrite = 1'b1;     // validValue stays 0
			end
			stLookup: begin
				if (!hit) begin
					// miss claims the line before the burst
					storeWrite.tagWrite   = 1'b1;
					storeWrite.validWrite = 1'b1;
					storeWrite.validValue = 1'b1;
				end
			end
			stFill: begin
				dramOp               = opFill;
				storeWrite.dataWrite = fillWord.strobe;   // one word per strobe
			end
			stHitHold, stFillHold: begin
				readWordSel = request.address[IndexLsb-1:WordLsb];
			end
			stWrite: begin
				dramOp                = opWrite;
				storeWrite.validWrite = lineValid;   // no allocate, drop a stale line
			end
			default: ;
		endcase
	end

	// writes hand the dram controller's dtack straight through
	assign dtack_L = (state == stWrite) ? !writeDtack : holdDtack_L;

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	sweepNoDtack: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state inside {stResetSweep, stInvalidate}) |-> dtack_L)
		else $error("dtack during invalidate sweep");

	// the burst port stays quiet for the whole write
	writeNoFill: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == stWrite) |-> (!fillWord.strobe && !fillDone))
		else $error("fill burst during a write");

endmodule

`default_nettype wire

// ==== source/dramBurstPort.sv ====
// dram controller burst port
`default_nettype none

module dramBurstPort (
	input  wire logic                              Clock,
	input  wire logic                              Reset_L,
	input  wire cachePkg::cpuReqT                  request,
	input  wire cachePkg::dramOpT                  dramOp,
	input  wire logic                              cas_L,
	input  wire logic                              ras_L,
	input  wire logic                              dramDtack_L,
	input  wire logic [cachePkg::DataWidth-1:0]    dramReadData,
	output logic                                   dramSelect_L,
	output logic                                   dramWe_L,
	output logic                                   dramAs_L,
	output logic                                   dramUds_L,
	output logic                                   dramLds_L,
	output logic [cachePkg::AddrWidth-1:0]         dramAddress,
	output logic [cachePkg::DataWidth-1:0]         dramWriteData,
	output cachePkg::fillWordT                     fillWord,
	output logic                                   fillDone,
	output logic                                   writeDtack
);

	import cachePkg::*;

	typedef enum logic [1:0] {
		bpWaitCas,    // fill requested, no read CAS yet
		bpLatency,    // counting CAS latency
		bpBurst,      // one word per clock
		bpDone        // fillDone pulse
	} burstStateT;

	burstStateT              burstState;
	logic [WordSelWidth-1:0] count;     // latency count, then burst word
	logic                    readCas;

	// refresh drops CAS with RAS low, a read has RAS high
	assign readCas = !cas_L && ras_L;

	////////////////////////////////////////////////////////////
	// dram controller pins
	////////////////////////////////////////////////////////////

	always_comb begin
		dramSelect_L  = 1'b1;
		dramWe_L      = 1'b1;
		dramAs_L      = 1'b1;
		dramUds_L     = 1'b1;
		dramLds_L     = 1'b1;
		dramAddress   = {request.address[AddrWidth-1:WordLsb], 1'b0};  // word address
		dramWriteData = request.writeData;

		case (dramOp)
			opFill: begin
				dramSelect_L = 1'b0;
				dramAs_L     = 1'b0;
				dramUds_L    = 1'b0;   // whole word even for a byte read
				dramLds_L    = 1'b0;
				dramAddress  = {request.address[AddrWidth-1:IndexLsb], {IndexLsb{1'b0}}};
			end
			opWrite: begin
				dramSelect_L = 1'b0;
				dramWe_L     = 1'b0;
				dramAs_L     = 1'b0;
				dramUds_L    = !request.upperStrobe;   // 68k byte lanes as given
				dramLds_L    = !request.lowerStrobe;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// burst timing
	////////////////////////////////////////////////////////////

	// CAS seen at edge 0, latency over at edge 2, words captured at edges 3..10
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			burstState <= bpWaitCas;
			count      <= '0;
		end else begin
			unique case (burstState)
				bpWaitCas: begin
					count <= '0;
					if ((dramOp == opFill) && readCas) begin
						burstState <= bpLatency;
					end
				end
				bpLatency: begin
					if (count == WordSelWidth'(CasLatency - 1)) begin
						count      <= '0;
						burstState <= bpBurst;
					end else begin
						count <= count + 1'b1;
					end
				end
				bpBurst: begin
					count <= count + 1'b1;   // wraps to 0 after the last word
					if (count == WordSelWidth'(LineWords - 1)) begin
						burstState <= bpDone;
					end
				end
				bpDone: burstState <= bpWaitCas;
				default: burstState <= bpWaitCas;
			endcase
		end
	end

	always_comb begin
		fillWord.strobe  = (burstState == bpBurst);
		fillWord.wordSel = count;
		fillWord.data    = dramReadData;   // stored at the end of the cycle
	end

	assign fillDone   = (burstState == bpDone);
	assign writeDtack = !dramDtack_L;

	// a fill is exactly one line, then fillDone
	oneLinePerFill: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(fillWord.strobe) |-> fillWord.strobe [*LineWords] ##1 (!fillWord.strobe && fillDone))
		else $error("burst strobe count is not one line");

endmodule

`default_nettype wire

// ==== source/lineStore.sv ====
// tag, valid and data arrays
`default_nettype none

module lineStore (
	input  wire logic                                 Clock,
	input  wire logic                                 Reset_L,
	input  wire logic [cachePkg::AddrWidth-1:0]       lookupAddress,
	input  wire cachePkg::storeWriteT                 storeWrite,
	input  wire logic [cachePkg::WordSelWidth-1:0]    readWordSel,
	output logic                                      hit,
	output logic                                      lineValid,
	output logic [cachePkg::DataWidth-1:0]            readData
);

	import cachePkg::*;

	logic [TagWidth-1:0]  tagArray  [NumLines];
	logic [NumLines-1:0]  validBits;                      // cleared by the sweep
	logic [DataWidth-1:0] dataArray [NumLines][LineWords];

	logic [IndexWidth-1:0] lookupIndex;   // registered request line
	logic [TagWidth-1:0]   lookupTag;     // registered request tag

	////////////////////////////////////////////////////////////
	// lookup register
	////////////////////////////////////////////////////////////

	// follows the bus every clock, hit is good one cycle later
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			lookupIndex <= '0;
			lookupTag   <= '0;
		end else begin
			lookupIndex <= lookupAddress[TagLsb-1:IndexLsb];
			lookupTag   <= lookupAddress[AddrWidth-1:TagLsb];
		end
	end

	////////////////////////////////////////////////////////////
	// array writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clock) begin
		if (storeWrite.tagWrite) begin
			tagArray[storeWrite.index] <= storeWrite.tag;
		end
		if (storeWrite.validWrite) begin
			validBits[storeWrite.index] <= storeWrite.validValue;
		end
		if (storeWrite.dataWrite) begin
			dataArray[storeWrite.index][storeWrite.wordSel] <= storeWrite.data;
		end
	end

	////////////////////////////////////////////////////////////
	// compare and read
	////////////////////////////////////////////////////////////

	assign lineValid = validBits[lookupIndex];
	assign hit       = lineValid && (tagArray[lookupIndex] == lookupTag);
	assign readData  = dataArray[lookupIndex][readWordSel];   // async read for the 68k

	// burst data must never land in a line that is being dropped
	noFillIntoInvalidate: assert property (@(posedge Clock) disable iff (!Reset_L)
		storeWrite.dataWrite |-> !(storeWrite.validWrite && !storeWrite.validValue))
		else $error("data write while clearing the line");

endmodule

`default_nettype wire

// ==== source/cachePkg.sv ====
// cache shared definitions
`default_nettype none

package cachePkg;

	////////////////////////////////////////////////////////////
	// geometry
	////////////////////////////////////////////////////////////

	localparam int AddrWidth    = 32;  // 68k byte address
	localparam int DataWidth    = 16;  // bus and cache word
	localparam int IndexWidth   = 5;   // 32 lines
	localparam int WordSelWidth = 3;   // 8 words per line
	localparam int TagWidth     = 23;  // address bits 31..9
	localparam int NumLines     = 32;
	localparam int LineWords    = 8;
	localparam int CasLatency   = 2;   // clocks from read CAS to first word

	// address field boundaries, bit 0 is the byte within a word
	localparam int WordLsb  = 1;
	localparam int IndexLsb = WordLsb + WordSelWidth;   // bit 4
	localparam int TagLsb   = IndexLsb + IndexWidth;    // bit 9

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// sequencer states
	typedef enum logic [2:0] {
		stResetSweep,   // one settle cycle out of reset
		stInvalidate,   // clear one valid bit per clock
		stIdle,
		stLookup,       // registered tag compare
		stHitHold,      // data from the line, dtack until AS rises
		stFill,         // burst from dram into the line
		stFillHold,     // filled, hand the word to the 68k
		stWrite         // write-through to dram
	} seqStateT;

	// what the dram port is asked to do
	typedef enum logic [1:0] {
		opNone,
		opFill,         // line-aligned burst read
		opWrite         // single word write
	} dramOpT;

	////////////////////////////////////////////////////////////
	// structs
	////////////////////////////////////////////////////////////

	// 68k access as seen on the pins, active high
	typedef struct packed {
		logic                 active;       // AS low and dram selected
		logic                 write;
		logic                 upperStrobe;  // bits 15..8
		logic                 lowerStrobe;  // bits 7..0
		logic [AddrWidth-1:0] address;
		logic [DataWidth-1:0] writeData;
	} cpuReqT;

	// one write into the line store, each enable a single-cycle strobe
	typedef struct packed {
		logic                    tagWrite;
		logic                    validWrite;
		logic                    validValue;
		logic                    dataWrite;
		logic [IndexWidth-1:0]   index;
		logic [WordSelWidth-1:0] wordSel;
		logic [TagWidth-1:0]     tag;
		logic [DataWidth-1:0]    data;
	} storeWriteT;

	// one burst word captured from dram
	typedef struct packed {
		logic                    strobe;
		logic [WordSelWidth-1:0] wordSel;
		logic [DataWidth-1:0]    data;
	} fillWordT;

endpackage

`default_nettype wire
